// File: design/snake_defines.svh
/* sizes assume a 160x120 grid that fits xCoord_t and yCoord_t.
   START and APPLE positions must be multiples of BLOCK_SIZE. */
`ifndef SNAKE_DEFINES_SVH
`define SNAKE_DEFINES_SVH

// visible pixel grid
`define SCREEN_WIDTH 160
`define SCREEN_HEIGHT 120

// one segment or apple, also the step of one move
`define BLOCK_SIZE 10
`define SNAKE_LENGTH 4

// head at reset, the rest hang below it
`define START_X 80
`define START_Y 60

// fixed apple origin
`define APPLE_X 30
`define APPLE_Y 30

// 3-bit rgb colours
`define APPLE_COLOUR 3'b100
`define BACKGROUND_COLOUR 3'b000
`define GAMEOVER_COLOUR 3'b111

// credits granted by the sink after reset
`define PIXEL_CREDITS 4

`endif

// File: design/snakePkg.sv
/* coordinate widths cover a 160x120 screen only.
   colours are 1 bit per rgb channel. */
package snakePkg;

    // pixel column, 0 to 159
    typedef logic [7:0] xCoord_t;

    // pixel row, 0 to 119
    typedef logic [6:0] yCoord_t;

    // rgb, one bit each, red in the msb
    typedef logic [2:0] colour_t;

    // direction of travel
    // up lowers the row, left lowers the column
    typedef enum logic [1:0]
    {
        headUp    = 2'd0,
        headDown  = 2'd1,
        headLeft  = 2'd2,
        headRight = 2'd3
    } heading_t;

endpackage

// File: design/snakeBody.sv
/* holds SNAKE_LENGTH positions of one axis, index 0 is the head.
   newHead is taken as given, no range check here. */
`include "snake_defines.svh"

module snakeBody
    import snakePkg::*;
#(
    parameter type coordT = xCoord_t,
    parameter coordT headStart = '0,
    parameter int stepSize = 0
)
(
    input  logic  Clock,
    input  logic  reset,
    input  logic  moveHead,
    input  coordT newHead,
    output coordT seg [0:`SNAKE_LENGTH-1]
);

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // start line, each segment one step behind the last
            for (int i = 0; i < `SNAKE_LENGTH; i++)
                seg[i] <= coordT'(headStart + i * stepSize);
        end
        else if (moveHead)
        begin
            // head takes the new spot
            seg[0] <= newHead;
            // the rest follow the one ahead
            for (int i = 1; i < `SNAKE_LENGTH; i++)
                seg[i] <= seg[i-1];
        end
    end

endmodule

// File: design/blockRaster.sv
/* one pixel per clock while a credit is held; blockStart only when idle.
   the sink must never return more credits than it took. */
`include "snake_defines.svh"

module blockRaster
    import snakePkg::*;
(
    input  logic    Clock,
    input  logic    reset,
    input  logic    blockStart,
    input  xCoord_t blockX,
    input  yCoord_t blockY,
    input  colour_t blockColour,
    input  logic    creditReturn,
    output logic    blockDone,
    output logic    pixelValid,
    output xCoord_t pixelX,
    output yCoord_t pixelY,
    output colour_t pixelColour
);

    typedef logic [$clog2(`BLOCK_SIZE)-1:0] blockPos_t;
    typedef logic [$clog2(`PIXEL_CREDITS + 1)-1:0] credit_t;

    logic      busy;
    blockPos_t colCount;
    blockPos_t rowCount;
    credit_t   creditCount;
    xCoord_t   originX;
    yCoord_t   originY;
    colour_t   colourReg;
    logic      lastCol;
    logic      lastRow;

    assign lastCol = (colCount == blockPos_t'(`BLOCK_SIZE - 1));
    assign lastRow = (rowCount == blockPos_t'(`BLOCK_SIZE - 1));

    // stalls in place with no credit
    assign pixelValid = busy && (creditCount != '0);

    // scan row by row, x fastest
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            blockDone <= 1'b0;
            colCount <= '0;
            rowCount <= '0;
        end
        else
        begin
            blockDone <= 1'b0;
            if (blockStart)
            begin
                busy <= 1'b1;
                colCount <= '0;
                rowCount <= '0;
            end
            else if (pixelValid)
            begin
                if (lastCol)
                begin
                    colCount <= '0;
                    if (lastRow)
                    begin
                        // done pulses the cycle after the last pixel
                        busy <= 1'b0;
                        blockDone <= 1'b1;
                    end
                    else
                        rowCount <= rowCount + 1'b1;
                end
                else
                    colCount <= colCount + 1'b1;
            end
        end
    end

    // a pixel takes one credit, a return gives one back
    always_ff @(posedge Clock)
    begin
        if (reset)
            creditCount <= credit_t'(`PIXEL_CREDITS);
        else if (pixelValid && !creditReturn)
            creditCount <= creditCount - 1'b1;
        else if (!pixelValid && creditReturn)
            creditCount <= creditCount + 1'b1;
    end

    // block origin and colour, caught at the request
    always_ff @(posedge Clock)
    begin
        if (blockStart)
        begin
            originX <= blockX;
            originY <= blockY;
            colourReg <= blockColour;
        end
    end

    assign pixelX = originX + xCoord_t'(colCount);
    assign pixelY = originY + yCoord_t'(rowCount);
    assign pixelColour = colourReg;

endmodule

// File: design/collisionCheck.sv
/* segments sit on the block grid, so a self hit is exact equality.
   an edge block counts as a wall hit. */
`include "snake_defines.svh"

module collisionCheck
    import snakePkg::*;
(
    input  xCoord_t segX [0:`SNAKE_LENGTH-1],
    input  yCoord_t segY [0:`SNAKE_LENGTH-1],
    output logic    collided
);

    logic wallHit;
    logic selfHit;

    // head on any screen edge
    always_comb
    begin
        wallHit = (segX[0] == '0) ||
                  (segX[0] == xCoord_t'(`SCREEN_WIDTH - `BLOCK_SIZE)) ||
                  (segY[0] == '0) ||
                  (segY[0] == yCoord_t'(`SCREEN_HEIGHT - `BLOCK_SIZE));
    end

    // head on top of any other segment
    always_comb
    begin
        selfHit = 1'b0;
        for (int i = 1; i < `SNAKE_LENGTH; i++)
        begin
            if ((segX[i] == segX[0]) && (segY[i] == segY[0]))
                selfHit = 1'b1;
        end
    end

    assign collided = wallHit || selfHit;

endmodule

// File: design/snakeController.sv
/* frames run only while start is high; keys are sampled once per move.
   after game over the FSM stays put until reset. */
`include "snake_defines.svh"

module snakeController
    import snakePkg::*;
#(
    parameter int tickBits = 20
)
(
    input  logic    Clock,
    input  logic    reset,
    input  logic    start,
    input  logic    keyRight,
    input  logic    keyDown,
    input  logic    keyUp,
    input  logic    keyLeft,
    input  colour_t snakeColour,
    input  logic    collided,
    input  logic    blockDone,
    input  xCoord_t segX [0:`SNAKE_LENGTH-1],
    input  yCoord_t segY [0:`SNAKE_LENGTH-1],
    output logic    blockStart,
    output xCoord_t blockX,
    output yCoord_t blockY,
    output colour_t blockColour,
    output logic    moveHead,
    output xCoord_t newHeadX,
    output yCoord_t newHeadY,
    output logic    gameOver
);

    typedef logic [$clog2(`SNAKE_LENGTH)-1:0] segIdx_t;

    typedef enum logic [3:0]
    {
        waitStart,
        drawApple,
        drawBody,
        waitTick,
        eraseBody,
        checkHit,
        moveSnake,
        drawOver,
        gameEnd
    } frameState_t;

    frameState_t         state;
    logic [tickBits-1:0] tickCount;
    logic                tick;
    heading_t            heading;
    heading_t            moveHeading;
    segIdx_t             segIndex;
    logic                blockBusy;
    logic                drawing;
    logic                lastSeg;

    // free-running move timer
    always_ff @(posedge Clock)
    begin
        if (reset)
            tickCount <= '0;
        else
            tickCount <= tickCount + 1'b1;
    end

    assign tick = (tickCount == '0);

    // priority right, down, up, left
    // no key keeps the old heading
    always_comb
    begin
        moveHeading = heading;
        if (keyRight)
            moveHeading = headRight;
        else if (keyDown)
            moveHeading = headDown;
        else if (keyUp)
            moveHeading = headUp;
        else if (keyLeft)
            moveHeading = headLeft;
    end

    // next head, one block along the heading loaded this move
    always_comb
    begin
        newHeadX = segX[0];
        newHeadY = segY[0];
        case (moveHeading)
            headUp:
                newHeadY = yCoord_t'(segY[0] - `BLOCK_SIZE);
            headDown:
                newHeadY = yCoord_t'(segY[0] + `BLOCK_SIZE);
            headLeft:
                newHeadX = xCoord_t'(segX[0] - `BLOCK_SIZE);
            default:
                newHeadX = xCoord_t'(segX[0] + `BLOCK_SIZE);
        endcase
    end

    // states that own the raster
    assign drawing = (state == drawApple) || (state == drawBody) ||
                     (state == eraseBody) || (state == drawOver);

    // one request per block, then wait for blockDone
    assign blockStart = drawing && !blockBusy;
    assign lastSeg = (segIndex == '0);

    // block source and colour per state
    always_comb
    begin
        blockX = segX[segIndex];
        blockY = segY[segIndex];
        blockColour = snakeColour;
        case (state)
            drawApple:
            begin
                blockX = xCoord_t'(`APPLE_X);
                blockY = yCoord_t'(`APPLE_Y);
                blockColour = colour_t'(`APPLE_COLOUR);
            end
            eraseBody:
                blockColour = colour_t'(`BACKGROUND_COLOUR);
            drawOver:
            begin
                // head only
                blockX = segX[0];
                blockY = segY[0];
                blockColour = colour_t'(`GAMEOVER_COLOUR);
            end
            default:
                blockColour = snakeColour;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= waitStart;
            heading <= headUp;
            segIndex <= segIdx_t'(`SNAKE_LENGTH - 1);
            blockBusy <= 1'b0;
        end
        else
        begin
            // outstanding from blockStart until blockDone
            if (blockStart)
                blockBusy <= 1'b1;
            else if (blockDone)
                blockBusy <= 1'b0;

            case (state)
                waitStart:
                    if (start && tick)
                        state <= drawApple;
                drawApple:
                    if (blockDone)
                        state <= drawBody;
                drawBody:
                    // tail to head, index back to the tail at the end
                    if (blockDone)
                    begin
                        if (lastSeg)
                        begin
                            segIndex <= segIdx_t'(`SNAKE_LENGTH - 1);
                            state <= waitTick;
                        end
                        else
                            segIndex <= segIndex - 1'b1;
                    end
                waitTick:
                    if (tick)
                        state <= eraseBody;
                eraseBody:
                    if (blockDone)
                    begin
                        if (lastSeg)
                        begin
                            segIndex <= segIdx_t'(`SNAKE_LENGTH - 1);
                            state <= checkHit;
                        end
                        else
                            segIndex <= segIndex - 1'b1;
                    end
                checkHit:
                    // collided only counts here
                    if (collided)
                        state <= drawOver;
                    else
                        state <= moveSnake;
                moveSnake:
                begin
                    heading <= moveHeading;
                    state <= waitStart;
                end
                drawOver:
                    if (blockDone)
                        state <= gameEnd;
                gameEnd:
                    state <= gameEnd;
                default:
                    state <= waitStart;
            endcase
        end
    end

    // single-cycle pulse, store updates on the next edge
    assign moveHead = (state == moveSnake);
    assign gameOver = (state == gameEnd);

endmodule

// File: design/snakeTop.sv
/* tickBits sets the move period as 2^tickBits clocks.
   the pixel sink must return one credit per pixel taken. */
`include "snake_defines.svh"

module snakeTop
    import snakePkg::*;
#(
    parameter int tickBits = 20
)
(
    input  logic    Clock,
    input  logic    reset,
    input  logic    start,
    input  logic    keyRight,
    input  logic    keyDown,
    input  logic    keyUp,
    input  logic    keyLeft,
    input  colour_t snakeColour,
    input  logic    creditReturn,
    output logic    pixelValid,
    output xCoord_t pixelX,
    output yCoord_t pixelY,
    output colour_t pixelColour,
    output logic    gameOver
);

    // segment positions, index 0 is the head
    xCoord_t segX [0:`SNAKE_LENGTH-1];
    yCoord_t segY [0:`SNAKE_LENGTH-1];

    // block request to the raster
    logic    blockStart;
    xCoord_t blockX;
    yCoord_t blockY;
    colour_t blockColour;
    logic    blockDone;

    // head update
    logic    moveHead;
    xCoord_t newHeadX;
    yCoord_t newHeadY;

    logic    collided;

    snakeController #(
        .tickBits(tickBits)
    ) controller (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .keyRight(keyRight),
        .keyDown(keyDown),
        .keyUp(keyUp),
        .keyLeft(keyLeft),
        .snakeColour(snakeColour),
        .collided(collided),
        .blockDone(blockDone),
        .segX(segX),
        .segY(segY),
        .blockStart(blockStart),
        .blockX(blockX),
        .blockY(blockY),
        .blockColour(blockColour),
        .moveHead(moveHead),
        .newHeadX(newHeadX),
        .newHeadY(newHeadY),
        .gameOver(gameOver)
    );

    // columns all start at START_X
    snakeBody #(
        .coordT(xCoord_t),
        .headStart(xCoord_t'(`START_X)),
        .stepSize(0)
    ) bodyX (
        .Clock(Clock),
        .reset(reset),
        .moveHead(moveHead),
        .newHead(newHeadX),
        .seg(segX)
    );

    // rows stack downward one block apart
    snakeBody #(
        .coordT(yCoord_t),
        .headStart(yCoord_t'(`START_Y)),
        .stepSize(`BLOCK_SIZE)
    ) bodyY (
        .Clock(Clock),
        .reset(reset),
        .moveHead(moveHead),
        .newHead(newHeadY),
        .seg(segY)
    );

    blockRaster raster (
        .Clock(Clock),
        .reset(reset),
        .blockStart(blockStart),
        .blockX(blockX),
        .blockY(blockY),
        .blockColour(blockColour),
        .creditReturn(creditReturn),
        .blockDone(blockDone),
        .pixelValid(pixelValid),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColour(pixelColour)
    );

    collisionCheck hitCheck (
        .segX(segX),
        .segY(segY),
        .collided(collided)
    );

endmodule

// File: dv/snake_assert.sv
/* bound twice, once on the raster for credits and coordinates, once on
   the controller for gameOver; inputs a binding does not use are tied off */
`include "snake_defines.svh"

module snakeAssert
    import snakePkg::*;
(
    input logic                                  Clock,
    input logic                                  reset,
    input logic                                  pixelValid,
    input logic [$clog2(`PIXEL_CREDITS + 1)-1:0] creditCount,
    input xCoord_t                               pixelX,
    input yCoord_t                               pixelY,
    input logic                                  gameOver
);

    // failures seen, summed by the testbench at the end
    int failCount = 0;

    // never a pixel without a credit in hand
    pixelNeedsCredit: assert property (@(posedge Clock) disable iff (reset)
        pixelValid |-> (creditCount != '0))
    else
    begin
        $error("pixel sent with no credit left");
        failCount++;
    end

    // sink never over-returns
    creditBound: assert property (@(posedge Clock) disable iff (reset)
        creditCount <= `PIXEL_CREDITS)
    else
    begin
        $error("credit count above the granted credits");
        failCount++;
    end

    pixelOnScreen: assert property (@(posedge Clock) disable iff (reset)
        pixelValid |-> ((pixelX < `SCREEN_WIDTH) && (pixelY < `SCREEN_HEIGHT)))
    else
    begin
        $error("pixel coordinate off the screen");
        failCount++;
    end

    // game over is sticky until reset
    gameOverHolds: assert property (@(posedge Clock) disable iff (reset)
        gameOver |=> gameOver)
    else
    begin
        $error("gameOver dropped without a reset");
        failCount++;
    end

endmodule

bind blockRaster snakeAssert rasterChecks (
    .Clock(Clock),
    .reset(reset),
    .pixelValid(pixelValid),
    .creditCount(creditCount),
    .pixelX(pixelX),
    .pixelY(pixelY),
    .gameOver(1'b0)
);

bind snakeController snakeAssert endChecks (
    .Clock(Clock),
    .reset(reset),
    .pixelValid(1'b0),
    .creditCount('0),
    .pixelX('0),
    .pixelY('0),
    .gameOver(gameOver)
);

// File: dv/snakeTb.sv
/* runs snakeTop with tickBits 6; expected pixels come from a model of the
   game rules. credit returns are immediate, held or randomly delayed */
`include "snake_defines.svh"

module snakeTb
    import snakePkg::*;
();

    localparam int clockPeriod = 8;
    localparam int tickPeriod = 64;
    // nine blocks per frame at up to 8 cycles a pixel plus tick waits
    localparam int frameCycles = 9 * `BLOCK_SIZE * `BLOCK_SIZE * 8 + 4 * tickPeriod;
    // frames of all tests plus one game-over block allowance per test
    localparam int testFrames = 1 + 1 + 7 + 3 + 2 + 3;
    localparam int testCount = 6;
    localparam longint watchdogTime =
        longint'((testFrames + testCount) * frameCycles + testCount * 1000) * clockPeriod;

    // sink credit behaviour
    localparam int creditsNow = 0;
    localparam int creditsHeld = 1;
    localparam int creditsRandom = 2;

    logic    Clock = 1'b0;
    logic    reset;
    logic    start;
    logic    keyRight;
    logic    keyDown;
    logic    keyUp;
    logic    keyLeft;
    colour_t snakeColour;
    logic    creditReturn = 1'b0;
    logic    pixelValid;
    xCoord_t pixelX;
    yCoord_t pixelY;
    colour_t pixelColour;
    logic    gameOver;

    // expected pixel stream with the next pixel at the front
    xCoord_t expX [$];
    yCoord_t expY [$];
    colour_t expC [$];

    // reference model of the snake
    xCoord_t  modelX [0:`SNAKE_LENGTH-1];
    yCoord_t  modelY [0:`SNAKE_LENGTH-1];
    heading_t modelHeading;

    string  testName = "reset";
    int     creditMode = creditsNow;
    int     owed = 0;
    int     pixelsSeen = 0;
    int     seed = 16235;
    int     valueErrors = 0;
    int     otherErrors = 0;
    int     assertErrors;
    logic   giveBack;

    snakeTop #(
        .tickBits(6)
    ) dut (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .keyRight(keyRight),
        .keyDown(keyDown),
        .keyUp(keyUp),
        .keyLeft(keyLeft),
        .snakeColour(snakeColour),
        .creditReturn(creditReturn),
        .pixelValid(pixelValid),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColour(pixelColour),
        .gameOver(gameOver)
    );

    always #(clockPeriod / 2) Clock = ~Clock;

    task automatic checkColumn(input xCoord_t expected, input xCoord_t actual);
        if (expected !== actual)
        begin
            valueErrors++;
            $display("FAILED %s: pixel x expected %0d, actual %0d", testName, expected, actual);
        end
    endtask

    task automatic checkRow(input yCoord_t expected, input yCoord_t actual);
        if (expected !== actual)
        begin
            valueErrors++;
            $display("FAILED %s: pixel y expected %0d, actual %0d", testName, expected, actual);
        end
    endtask

    task automatic checkColour(input colour_t expected, input colour_t actual);
        if (expected !== actual)
        begin
            valueErrors++;
            $display("FAILED %s: colour expected %b, actual %b", testName, expected, actual);
        end
    endtask

    task automatic checkGameOver(input logic expected, input logic actual);
        if (expected !== actual)
        begin
            valueErrors++;
            $display("FAILED %s: gameOver expected %b, actual %b", testName, expected, actual);
        end
    endtask

    task automatic checkCount(input int expected, input int actual);
        if (expected != actual)
        begin
            valueErrors++;
            $display("FAILED %s: pixel count expected %0d, actual %0d",
                     testName, expected, actual);
        end
    endtask

    // pixel sink samples mid-cycle and decides this cycle's credit return
    always @(negedge Clock)
    begin
        if (reset)
        begin
            owed = 0;
            pixelsSeen = 0;
            creditReturn = 1'b0;
        end
        else
        begin
            if (pixelValid)
            begin
                pixelsSeen++;
                owed++;
                if (expX.size() == 0)
                begin
                    otherErrors++;
                    $display("%s: unexpected pixel at %0d,%0d after the stream should end",
                             testName, pixelX, pixelY);
                end
                else
                begin
                    checkColumn(expX.pop_front(), pixelX);
                    checkRow(expY.pop_front(), pixelY);
                    checkColour(expC.pop_front(), pixelColour);
                end
            end
            case (creditMode)
                creditsHeld:
                    giveBack = 1'b0;
                creditsRandom:
                    giveBack = (owed > 0) && (($random(seed) & 3) == 0);
                default:
                    giveBack = (owed > 0);
            endcase
            creditReturn = giveBack;
            if (giveBack)
                owed--;
        end
    end

    task automatic queueBlock(input xCoord_t x, input yCoord_t y, input colour_t c);
        // row by row with x fastest
        for (int r = 0; r < `BLOCK_SIZE; r++)
        begin
            for (int col = 0; col < `BLOCK_SIZE; col++)
            begin
                expX.push_back(xCoord_t'(x + col));
                expY.push_back(yCoord_t'(y + r));
                expC.push_back(c);
            end
        end
    endtask

    task automatic resetModel();
        for (int i = 0; i < `SNAKE_LENGTH; i++)
        begin
            modelX[i] = xCoord_t'(`START_X);
            modelY[i] = yCoord_t'(`START_Y + i * `BLOCK_SIZE);
        end
        modelHeading = headUp;
    endtask

    // head on an edge block or on another segment
    function automatic logic modelHit();
        logic hit;
        hit = (modelX[0] == 0) || (modelX[0] == `SCREEN_WIDTH - `BLOCK_SIZE) ||
              (modelY[0] == 0) || (modelY[0] == `SCREEN_HEIGHT - `BLOCK_SIZE);
        for (int i = 1; i < `SNAKE_LENGTH; i++)
        begin
            if ((modelX[i] == modelX[0]) && (modelY[i] == modelY[0]))
                hit = 1'b1;
        end
        return hit;
    endfunction

    // one frame of pixels followed by the check and the move
    task automatic modelFrame(output logic ended);
        xCoord_t hx;
        yCoord_t hy;
        queueBlock(xCoord_t'(`APPLE_X), yCoord_t'(`APPLE_Y), colour_t'(`APPLE_COLOUR));
        for (int i = `SNAKE_LENGTH - 1; i >= 0; i--)
            queueBlock(modelX[i], modelY[i], snakeColour);
        for (int i = `SNAKE_LENGTH - 1; i >= 0; i--)
            queueBlock(modelX[i], modelY[i], colour_t'(`BACKGROUND_COLOUR));
        ended = modelHit();
        if (ended)
            queueBlock(modelX[0], modelY[0], colour_t'(`GAMEOVER_COLOUR));
        else
        begin
            // key priority right, down, up, left
            if (keyRight)
                modelHeading = headRight;
            else if (keyDown)
                modelHeading = headDown;
            else if (keyUp)
                modelHeading = headUp;
            else if (keyLeft)
                modelHeading = headLeft;
            hx = modelX[0];
            hy = modelY[0];
            case (modelHeading)
                headUp:
                    hy = yCoord_t'(hy - `BLOCK_SIZE);
                headDown:
                    hy = yCoord_t'(hy + `BLOCK_SIZE);
                headLeft:
                    hx = xCoord_t'(hx - `BLOCK_SIZE);
                default:
                    hx = xCoord_t'(hx + `BLOCK_SIZE);
            endcase
            for (int i = `SNAKE_LENGTH - 1; i > 0; i--)
            begin
                modelX[i] = modelX[i-1];
                modelY[i] = modelY[i-1];
            end
            modelX[0] = hx;
            modelY[0] = hy;
        end
    endtask

    task automatic startTest(input string name, input int mode);
        @(negedge Clock);
        testName = name;
        creditMode = mode;
        start = 1'b0;
        keyRight = 1'b0;
        keyDown = 1'b0;
        keyUp = 1'b0;
        keyLeft = 1'b0;
        reset = 1'b1;
        repeat (16) @(negedge Clock);
        expX.delete();
        expY.delete();
        expC.delete();
        reset = 1'b0;
        resetModel();
    endtask

    // wait until every expected pixel has arrived
    task automatic waitDrained(input int frames);
        int cycles;
        cycles = 0;
        while ((expX.size() != 0) && (cycles < frames * frameCycles))
        begin
            @(posedge Clock);
            cycles++;
        end
        if (expX.size() != 0)
        begin
            otherErrors++;
            $display("%s: timed out with %0d pixels still missing", testName, expX.size());
            expX.delete();
            expY.delete();
            expC.delete();
        end
    endtask

    task automatic runFrames(input int maxFrames);
        int   frames;
        int   waited;
        logic ended;
        frames = 0;
        ended = 1'b0;
        while (!ended && (frames < maxFrames))
        begin
            modelFrame(ended);
            frames++;
        end
        @(negedge Clock);
        start = 1'b1;
        waitDrained(frames + 1);
        @(negedge Clock);
        // a stopped game must stay silent with start still high
        if (!ended)
            start = 1'b0;
        waited = 0;
        while (ended && !gameOver && (waited < 16))
        begin
            @(posedge Clock);
            waited++;
        end
        // quiet window where the sink flags any stray pixel
        repeat (3 * tickPeriod) @(posedge Clock);
        checkGameOver(ended, gameOver);
        @(negedge Clock);
        start = 1'b0;
    endtask

    task automatic creditLimitTest();
        int   waited;
        logic ended;
        startTest("credit limit", creditsHeld);
        modelFrame(ended);
        start = 1'b1;
        waited = 0;
        while ((pixelsSeen < `PIXEL_CREDITS) && (waited < 3 * tickPeriod))
        begin
            @(posedge Clock);
            waited++;
        end
        repeat (100) @(posedge Clock);
        checkCount(`PIXEL_CREDITS, pixelsSeen);
        // release the credits so the stream resumes where it stalled
        creditMode = creditsNow;
        waitDrained(2);
        @(negedge Clock);
        start = 1'b0;
        repeat (3 * tickPeriod) @(posedge Clock);
        checkGameOver(1'b0, gameOver);
    endtask

    task automatic firstFrameTest();
        startTest("first frame", creditsNow);
        snakeColour = 3'b010;
        runFrames(1);
    endtask

    task automatic wallHitTest();
        startTest("up into wall", creditsNow);
        runFrames(10);
    endtask

    task automatic turnRightTest();
        startTest("turn right", creditsNow);
        keyRight = 1'b1;
        runFrames(3);
    endtask

    task automatic reverseHitTest();
        startTest("reverse into body", creditsNow);
        keyDown = 1'b1;
        runFrames(3);
    endtask

    task automatic randomCreditTest();
        startTest("random credits", creditsRandom);
        snakeColour = 3'b011;
        keyLeft = 1'b1;
        runFrames(3);
    endtask

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        keyRight = 1'b0;
        keyDown = 1'b0;
        keyUp = 1'b0;
        keyLeft = 1'b0;
        snakeColour = 3'b010;
        creditLimitTest();
        firstFrameTest();
        wallHitTest();
        turnRightTest();
        reverseHitTest();
        randomCreditTest();
        assertErrors = dut.raster.rasterChecks.failCount + dut.controller.endChecks.failCount;
        $display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
                 valueErrors, otherErrors, assertErrors);
        if ((valueErrors + otherErrors + assertErrors) == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // run bound from the frame budget of all tests
    initial
    begin
        #(watchdogTime);
        $display("watchdog expired in %s before the tests finished", testName);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/snakePkg.sv
design/snakeBody.sv
design/blockRaster.sv
design/collisionCheck.sv
design/snakeController.sv
design/snakeTop.sv
dv/snake_assert.sv
dv/snakeTb.sv
